// ==== bench/tb_rover_link.sv ====
`timescale 1ns/1ps

module tb_rover_link;

    localparam int FRAME_LEN       = rover_pkg::FRAME_LEN;
    localparam int FRAMES_SENT     = 37;   // Frames the whole sequence sends
    localparam int WATCHDOG_CYCLES = FRAMES_SENT * 280 * rover_pkg::CLKS_PER_BIT
                                     + 2 * rover_pkg::HEARTBEAT_CYCLES;

    logic                   clk;
    logic                   arst_n;
    rover_pkg::drive_cmd_t  host_cmd;
    rover_pkg::speed_step_t host_step;
    logic                   cmd_update;
    logic                   txd;
    logic                   frame_busy;
    rover_pkg::byte_t       rx_byte;
    logic                   rx_start;
    logic                   rx_stop;
    logic                   rx_valid;
    rover_pkg::byte_t       rx_q[$];   // Decoded bytes not yet checked
    logic [15:0]            lfsr;
    int                     frames_seen;
    int                     odd_steps[5] = '{0, 4, 5, 6, 7};

    rover_link_top UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .host_cmd   (host_cmd),
        .host_step  (host_step),
        .cmd_update (cmd_update),
        .txd        (txd),
        .frame_busy (frame_busy)
    );

    uart_monitor u_monitor (
        .clk      (clk),
        .arst_n   (arst_n),
        .txd      (txd),
        .rx_byte  (rx_byte),
        .rx_start (rx_start),
        .rx_stop  (rx_stop),
        .rx_valid (rx_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("timeout, the run did not finish in %0d cycles", WATCHDOG_CYCLES));
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // Line checks on every cycle out of reset
    always @(posedge clk) begin
        if (arst_n === 1'b1) begin
            if (frame_busy !== 1'b1) begin
                assert (txd === 1'b1)
                else abort_run($sformatf("error at time %0t: txd low while idle", $realtime));
            end
            if (rx_valid === 1'b1) begin
                assert (rx_start === 1'b0 && rx_stop === 1'b1)
                else abort_run($sformatf("error at time %0t: bad start or stop bit",
                                         $realtime));
                assert (frame_busy === 1'b1)
                else abort_run($sformatf("error at time %0t: byte sent without frame_busy",
                                         $realtime));
                rx_q.push_back(rx_byte);
            end
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // Taps 16 14 13 11
    endfunction

    task automatic rand_bits(input int n, output logic [2:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[1:0], lfsr[0]};
        end
    endtask

    // Expected text rebuilt from the wheel speed table
    function automatic string expected_frame(input int code, input int step);
        int s;
        int l;
        int r;
        s = (step < 1) ? 1 : ((step > 3) ? 3 : step);
        case (code)
            1:       l = 50;
            2:       l = 10 * s;
            3:       l = 10 * s - 5;
            4:       l = 5 * s;
            5:       l = 20;
            default: return "{\"T\":0,\"L\":00.00,\"R\":00.00}\n";
        endcase
        case (code)
            1:       r = 20;
            2:       r = 5 * s;
            3:       r = l;   // Both wheels equal
            4:       r = 10 * s;
            default: r = 50;
        endcase
        return $sformatf("{\"T\":1,\"L\":-0.%02d,\"R\":-0.%02d}\n", l, r);
    endfunction

    task automatic send_cmd(input int code, input int step);
        logic [2:0] c3;
        logic [2:0] s3;
        c3 = code[2:0];
        s3 = step[2:0];
        @(posedge clk);
        host_cmd   <= rover_pkg::drive_cmd_t'(c3);
        host_step  <= s3;
        cmd_update <= 1'b1;
        @(posedge clk);
        cmd_update <= 1'b0;
    endtask

    task automatic check_frame(input int code, input int step);
        string            exp;
        rover_pkg::byte_t got;
        int               i;
        exp = expected_frame(code, step);
        while (rx_q.size() < FRAME_LEN) @(posedge clk);
        for (i = 0; i < FRAME_LEN; i++) begin
            got = rx_q.pop_front();
            assert (got === exp[i])
            else abort_run($sformatf(
                "error at time %0t: frame %0d byte %0d is 0x%02h, want 0x%02h",
                $realtime, frames_seen, i, got, exp[i]));
        end
        frames_seen++;
    endtask

    initial begin
        int         code;
        int         step;
        int         k;
        int         quiet;
        logic [2:0] rc;
        logic [2:0] rs;
        arst_n      <= 1'b0;
        host_cmd    <= rover_pkg::CMD_STOP;
        host_step   <= '0;
        cmd_update  <= 1'b0;
        lfsr        = 16'd5036;
        frames_seen = 0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        assert (txd === 1'b1 && frame_busy === 1'b0)
        else abort_run($sformatf("error at time %0t: wrong line state after reset", $realtime));

        for (code = 0; code <= 5; code++) begin
            for (step = 1; step <= 3; step++) begin
                send_cmd(code, step);
                check_frame(code, step);
            end
        end
        // Out of range steps and unknown codes
        for (k = 0; k < 5; k++) begin
            send_cmd(2 + k % 3, odd_steps[k]);
            check_frame(2 + k % 3, odd_steps[k]);
        end
        for (code = 6; code <= 7; code++) begin
            send_cmd(code, 2);
            check_frame(code, 2);
        end
        for (k = 0; k < 8; k++) begin
            rand_bits(3, rc);
            rand_bits(3, rs);
            send_cmd(int'(rc), int'(rs));
            check_frame(int'(rc), int'(rs));
        end

        // Two updates during a frame leave one more frame, newest wins
        send_cmd(3, 2);
        while (rx_q.size() == 0) @(posedge clk);
        send_cmd(1, 1);
        send_cmd(5, 3);
        check_frame(3, 2);
        check_frame(5, 3);
        repeat (500) @(posedge clk);
        assert (rx_q.size() == 0 && frame_busy === 1'b0)
        else abort_run($sformatf("error at time %0t: extra frame after queued updates", $realtime));

        // Heartbeat repeats the last command after the quiet time
        send_cmd(4, 2);
        check_frame(4, 2);
        while (frame_busy === 1'b1) @(posedge clk);
        quiet = 0;
        while (frame_busy !== 1'b1) begin
            @(posedge clk);
            quiet++;
        end
        assert (quiet >= rover_pkg::HEARTBEAT_CYCLES && quiet <= rover_pkg::HEARTBEAT_CYCLES + 16)
        else abort_run($sformatf("error at time %0t: heartbeat after %0d idle cycles",
                                 $realtime, quiet));
        check_frame(4, 2);

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== bench/uart_monitor.sv ====
`timescale 1ns/1ps

module uart_monitor (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             txd,
    output rover_pkg::byte_t rx_byte,
    output logic             rx_start,   // Line level in the middle of the start bit
    output logic             rx_stop,    // Line level in the middle of the stop bit
    output logic             rx_valid
);

    localparam int HALF_BIT = rover_pkg::CLKS_PER_BIT / 2;

    rover_pkg::byte_t shift;

    // Samples each bit near its middle, counted in clock cycles
    initial begin
        int i;
        rx_byte  <= '0;
        rx_start <= 1'b1;
        rx_stop  <= 1'b1;
        rx_valid <= 1'b0;
        shift = '0;
        forever begin
            @(posedge clk);
            rx_valid <= 1'b0;
            if (arst_n === 1'b1 && txd === 1'b0) begin
                // First low sample is one cycle into the start bit
                repeat (HALF_BIT - 1) @(posedge clk);
                rx_start <= txd;
                for (i = 0; i < 8; i++) begin
                    repeat (rover_pkg::CLKS_PER_BIT) @(posedge clk);
                    shift[i] = txd;   // LSB arrives first
                end
                repeat (rover_pkg::CLKS_PER_BIT) @(posedge clk);
                rx_stop  <= txd;
                rx_byte  <= shift;
                rx_valid <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/drive_scheduler.sv ====
`timescale 1ns/1ps

module drive_scheduler (
    input  logic                   clk,
    input  logic                   arst_n,
    input  rover_pkg::drive_cmd_t  host_cmd,
    input  rover_pkg::speed_step_t host_step,
    input  logic                   cmd_update,
    input  logic                   gen_ready,
    input  logic                   frame_done,
    output logic                   send_req,
    output rover_pkg::drive_cmd_t  cmd,
    output rover_pkg::speed_step_t step
);

    typedef enum logic [1:0] {
        SCH_IDLE,
        SCH_REQ,     // Waiting for the generator to take the frame
        SCH_FLIGHT   // Frame on its way out
    } sched_state_t;

    sched_state_t       state;
    logic               pending;    // A frame still has to go out
    logic               hb_armed;   // Set once the first frame has finished
    rover_pkg::hb_cnt_t hb_cnt;
    logic               hb_count_en;
    logic               hb_fire;
    logic               accept;

    assign send_req    = (state == SCH_REQ);
    assign accept      = send_req && gen_ready;
    assign hb_count_en = hb_armed && (state == SCH_IDLE) && !pending;
    assign hb_fire     = hb_count_en && (hb_cnt == rover_pkg::HB_LAST);

    // Latest host command, newest update wins
    always_ff @(posedge clk) begin
        if (cmd_update) begin
            cmd  <= host_cmd;
            step <= host_step;
        end
    end

    // An update landing on the accept cycle keeps the flag set
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
        end else if (cmd_update || hb_fire) begin
            pending <= 1'b1;
        end else if (accept) begin
            pending <= 1'b0;
        end
    end

    // Quiet-time counter, restarted by every finished frame
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hb_armed <= 1'b0;
            hb_cnt   <= '0;
        end else if (frame_done) begin
            hb_armed <= 1'b1;
            hb_cnt   <= '0;
        end else if (hb_fire) begin
            hb_cnt <= '0;
        end else if (hb_count_en) begin
            hb_cnt <= hb_cnt + rover_pkg::hb_cnt_t'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= SCH_IDLE;
        end else begin
            case (state)
                SCH_IDLE:   if (pending) state <= SCH_REQ;
                SCH_REQ:    if (gen_ready) state <= SCH_FLIGHT;
                SCH_FLIGHT: if (frame_done) state <= SCH_IDLE;
                default:    state <= SCH_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/json_frame_gen.sv ====
`timescale 1ns/1ps

module json_frame_gen (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   send_req,
    input  rover_pkg::drive_cmd_t  cmd,
    input  rover_pkg::speed_step_t step,
    output logic                   gen_ready,
    output logic                   byte_valid,
    output rover_pkg::byte_t       tx_byte,
    input  logic                   tx_ready,
    output logic                   frame_done
);

    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_SEND,    // Bytes offered to the transmitter
        GEN_DRAIN    // Newline still shifting out
    } gen_state_t;

    gen_state_t             state;
    rover_pkg::frame_idx_t  idx;
    rover_pkg::drive_cmd_t  cmd_q;
    rover_pkg::speed_step_t step_q;
    rover_pkg::wheel_bcd_t  left_bcd;
    rover_pkg::wheel_bcd_t  right_bcd;
    logic                   moving;

    // Speed table in hundredths, left wheel in the upper byte
    function automatic logic [15:0] wheel_lookup(
        input rover_pkg::drive_cmd_t  c,
        input rover_pkg::speed_step_t s
    );
        case (c)
            rover_pkg::CMD_HARD_LEFT:  wheel_lookup = 16'h5020;
            rover_pkg::CMD_LEFT: begin
                case (s)
                    3'd1:    wheel_lookup = 16'h1005;
                    3'd2:    wheel_lookup = 16'h2010;
                    default: wheel_lookup = 16'h3015;
                endcase
            end
            rover_pkg::CMD_STRAIGHT: begin
                case (s)
                    3'd1:    wheel_lookup = 16'h0505;
                    3'd2:    wheel_lookup = 16'h1515;
                    default: wheel_lookup = 16'h2525;
                endcase
            end
            rover_pkg::CMD_RIGHT: begin
                case (s)
                    3'd1:    wheel_lookup = 16'h0510;
                    3'd2:    wheel_lookup = 16'h1020;
                    default: wheel_lookup = 16'h1530;
                endcase
            end
            rover_pkg::CMD_HARD_RIGHT: wheel_lookup = 16'h2050;
            default:                   wheel_lookup = 16'h0000;   // Stop
        endcase
    endfunction

    assign gen_ready  = (state == GEN_IDLE);
    assign byte_valid = (state == GEN_SEND);
    assign moving     = (cmd_q != rover_pkg::CMD_STOP);
    assign {left_bcd, right_bcd} = wheel_lookup(cmd_q, step_q);

    // Command held for the whole frame
    always_ff @(posedge clk) begin
        if (send_req && gen_ready) begin
            cmd_q <= (cmd > rover_pkg::CMD_HARD_RIGHT) ? rover_pkg::CMD_STOP : cmd;
            if (step < rover_pkg::STEP_MIN) begin
                step_q <= rover_pkg::STEP_MIN;
            end else if (step > rover_pkg::STEP_MAX) begin
                step_q <= rover_pkg::STEP_MAX;
            end else begin
                step_q <= step;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= GEN_IDLE;
            idx        <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                GEN_IDLE: begin
                    if (send_req) begin
                        state <= GEN_SEND;
                        idx   <= '0;
                    end
                end
                GEN_SEND: begin
                    if (tx_ready) begin   // Byte taken
                        if (idx == rover_pkg::LAST_IDX) begin
                            state <= GEN_DRAIN;
                        end else begin
                            idx <= idx + rover_pkg::frame_idx_t'(1);
                        end
                    end
                end
                GEN_DRAIN: begin
                    // Transmitter idle again once the last stop bit is out
                    if (tx_ready) begin
                        state      <= GEN_IDLE;
                        frame_done <= 1'b1;
                    end
                end
                default: state <= GEN_IDLE;
            endcase
        end
    end

    // {"T":1,"L":-0.10,"R":-0.05} then newline
    always_comb begin
        case (idx)
            5'd0:                                 tx_byte = rover_pkg::ASC_LBRACE;
            5'd1, 5'd3, 5'd7, 5'd9, 5'd17, 5'd19: tx_byte = rover_pkg::ASC_QUOTE;
            5'd2:                                 tx_byte = rover_pkg::ASC_T;
            5'd4, 5'd10, 5'd20:                   tx_byte = rover_pkg::ASC_COLON;
            5'd5:  tx_byte = moving ? rover_pkg::ASC_ONE : rover_pkg::ASC_ZERO;
            5'd6, 5'd16:                          tx_byte = rover_pkg::ASC_COMMA;
            5'd8:                                 tx_byte = rover_pkg::ASC_L;
            5'd18:                                tx_byte = rover_pkg::ASC_R;
            5'd11, 5'd21: tx_byte = moving ? rover_pkg::ASC_MINUS : rover_pkg::ASC_ZERO;
            5'd12, 5'd22:                         tx_byte = rover_pkg::ASC_ZERO;
            5'd13, 5'd23:                         tx_byte = rover_pkg::ASC_POINT;
            5'd14: tx_byte = {4'h3, left_bcd[7:4]};    // ASCII digit
            5'd15: tx_byte = {4'h3, left_bcd[3:0]};
            5'd24: tx_byte = {4'h3, right_bcd[7:4]};
            5'd25: tx_byte = {4'h3, right_bcd[3:0]};
            5'd26:                                tx_byte = rover_pkg::ASC_RBRACE;
            default:                              tx_byte = rover_pkg::ASC_NEWLINE;
        endcase
    end

endmodule

// ==== rtl/rover_link_top.sv ====
`timescale 1ns/1ps

module rover_link_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  rover_pkg::drive_cmd_t  host_cmd,
    input  rover_pkg::speed_step_t host_step,
    input  logic                   cmd_update,
    output logic                   txd,
    output logic                   frame_busy
);

    logic                   send_req;
    logic                   gen_ready;
    logic                   frame_done;
    logic                   byte_valid;
    logic                   tx_ready;
    rover_pkg::drive_cmd_t  cmd;
    rover_pkg::speed_step_t step;
    rover_pkg::byte_t       tx_byte;

    // Generator stays out of idle until the newline has left the line
    assign frame_busy = ~gen_ready;

    drive_scheduler u_scheduler (
        .clk        (clk),
        .arst_n     (arst_n),
        .host_cmd   (host_cmd),
        .host_step  (host_step),
        .cmd_update (cmd_update),
        .gen_ready  (gen_ready),
        .frame_done (frame_done),
        .send_req   (send_req),
        .cmd        (cmd),
        .step       (step)
    );

    json_frame_gen u_frame_gen (
        .clk        (clk),
        .arst_n     (arst_n),
        .send_req   (send_req),
        .cmd        (cmd),
        .step       (step),
        .gen_ready  (gen_ready),
        .byte_valid (byte_valid),
        .tx_byte    (tx_byte),
        .tx_ready   (tx_ready),
        .frame_done (frame_done)
    );

    uart_tx u_uart_tx (
        .clk        (clk),
        .arst_n     (arst_n),
        .byte_valid (byte_valid),
        .tx_byte    (tx_byte),
        .tx_ready   (tx_ready),
        .txd        (txd)
    );

endmodule

// ==== rtl/rover_pkg.sv ====
package rover_pkg;

    // One ASCII character or UART data byte
    typedef logic [7:0] byte_t;

    // Host drive codes, 6 and 7 fall back to stop
    typedef enum logic [2:0] {
        CMD_STOP       = 3'd0,
        CMD_HARD_LEFT  = 3'd1,
        CMD_LEFT       = 3'd2,
        CMD_STRAIGHT   = 3'd3,
        CMD_RIGHT      = 3'd4,
        CMD_HARD_RIGHT = 3'd5
    } drive_cmd_t;

    typedef logic [2:0] speed_step_t;

    // Valid speed step range after clamping
    localparam speed_step_t STEP_MIN = 3'd1;
    localparam speed_step_t STEP_MAX = 3'd3;

    // Frame layout
    localparam int FRAME_LEN = 28;             // Including the trailing newline
    typedef logic [4:0] frame_idx_t;
    localparam frame_idx_t LAST_IDX = frame_idx_t'(FRAME_LEN - 1);

    // Two BCD digits of a wheel speed in hundredths
    typedef logic [7:0] wheel_bcd_t;

    // UART bit timing
    localparam int CLKS_PER_BIT = 8;           // Short period for simulation
    localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
    typedef logic [BIT_CNT_W-1:0] bit_cnt_t;
    localparam bit_cnt_t BIT_LAST = bit_cnt_t'(CLKS_PER_BIT - 1);

    // Quiet time after a frame before the command is repeated
    localparam int HEARTBEAT_CYCLES = 6000;
    localparam int HB_CNT_W = $clog2(HEARTBEAT_CYCLES);
    typedef logic [HB_CNT_W-1:0] hb_cnt_t;
    localparam hb_cnt_t HB_LAST = hb_cnt_t'(HEARTBEAT_CYCLES - 1);

    // Fixed characters of the JSON text
    localparam byte_t ASC_LBRACE  = 8'h7b;   // {
    localparam byte_t ASC_RBRACE  = 8'h7d;   // }
    localparam byte_t ASC_QUOTE   = 8'h22;
    localparam byte_t ASC_COLON   = 8'h3a;
    localparam byte_t ASC_COMMA   = 8'h2c;
    localparam byte_t ASC_POINT   = 8'h2e;
    localparam byte_t ASC_MINUS   = 8'h2d;
    localparam byte_t ASC_ZERO    = 8'h30;
    localparam byte_t ASC_ONE     = 8'h31;
    localparam byte_t ASC_T       = 8'h54;
    localparam byte_t ASC_L       = 8'h4c;
    localparam byte_t ASC_R       = 8'h52;
    localparam byte_t ASC_NEWLINE = 8'h0a;

endpackage

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             byte_valid,
    input  rover_pkg::byte_t tx_byte,
    output logic             tx_ready,
    output logic             txd
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t           state;
    rover_pkg::bit_cnt_t cnt;       // Cycles into the current bit
    logic [2:0]          bit_idx;   // Data bit on the line
    rover_pkg::byte_t    data_q;
    logic                bit_end;

    assign tx_ready = (state == TX_IDLE);
    assign bit_end  = (cnt == rover_pkg::BIT_LAST);

    always_ff @(posedge clk) begin
        if (tx_ready && byte_valid) begin
            data_q <= tx_byte;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;   // Line idles high
        end else begin
            cnt <= (state == TX_IDLE || bit_end) ? '0 : cnt + rover_pkg::bit_cnt_t'(1);
            case (state)
                TX_IDLE: begin
                    if (byte_valid) begin
                        state <= TX_START;
                        txd   <= 1'b0;   // Start bit
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        txd     <= data_q[0];   // LSB first
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            txd   <= 1'b1;   // Stop bit
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            txd     <= data_q[bit_idx + 3'd1];
                        end
                    end
                end
                TX_STOP: if (bit_end) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rover link testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f sim.f \
        --top-module tb_rover_link -o tb_rover_link; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_rover_link > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -q "TEST PASS" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1

// ==== sim.f ====
rtl/rover_pkg.sv
rtl/drive_scheduler.sv
rtl/json_frame_gen.sv
rtl/uart_tx.sv
rtl/rover_link_top.sv
bench/uart_monitor.sv
bench/tb_rover_link.sv
